// File: Bender.yml
package:
  name: vex_top

sources:
  - files:
      - hdl/vex_pkg.sv
      - hdl/vector_lane.sv
      - hdl/vex_decode.sv
      - hdl/vex_execute.sv
      - hdl/vex_result.sv
      - hdl/vex_top.sv
  - target: simulation
    files:
      - bench/vex_tb.sv

// File: bench/vex_tb.sv
// runs with NUM_LANES = 2; the fixed seed gives the same stimulus on every run
`timescale 1ns/1ps

module vex_tb
  import vex_pkg::*;
();

  localparam int NUM_LANES = 2;
  localparam int MAX_WAIT  = 20;

  // expected result of one accepted instruction
  // hops counts the stages it has entered
  typedef struct packed {
    logic [1:0]                 hops;
    logic                       load;
    logic                       store;
    logic                       cfg;
    logic [4:0]                 vd;
    logic [NUM_LANES-1:0]       wen;
    logic [NUM_LANES-1:0][31:0] data;
    logic [31:0]                wb_data;
  } expect_t;

  logic                          CLK;
  logic                          nRST;
  logic                          issue;
  vex_instr_u                    instr;
  vex_scalar_t                   scalar;
  logic [NUM_LANES-1:0][31:0]    vs1;
  logic [NUM_LANES-1:0][31:0]    vs2;
  logic [NUM_LANES-1:0]          mask;
  logic                          stall;
  logic                          flush;
  logic                          res_valid;
  logic                          res_load;
  logic                          res_store;
  logic [4:0]                    res_vd;
  vex_lane_out_t [NUM_LANES-1:0] lanes;
  vex_wb_t                       wb;
  logic                          busy;
  expect_t                       model[$];

  vex_top #(.NUM_LANES(NUM_LANES)) u_dut (
    .CLK, .nRST, .issue, .instr, .scalar, .vs1, .vs2, .mask, .stall, .flush,
    .res_valid, .res_load, .res_store, .res_vd, .lanes, .wb, .busy
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] source(vex_src_e sel, logic [31:0] vec, logic [31:0] imm,
                                         logic [31:0] xs);
    return (sel == V) ? vec : (sel == I) ? imm : (sel == X) ? xs : 32'd0;
  endfunction

  function automatic logic [31:0] alu_model(vex_aluop_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return 32'($signed(a) >>> b[4:0]);
      MIN:     return ($signed(a) > $signed(b)) ? b : a;
      MAX:     return ($signed(a) > $signed(b)) ? a : b;
      MINU:    return (a > b) ? b : a;
      MAXU:    return (a > b) ? a : b;
      MUL:     return a * b;
      default: return 32'd0;
    endcase
  endfunction

  // what the result stage must show for the instruction now on the inputs
  function automatic expect_t expected_result();
    expect_t     e;
    vex_arith_t  ar;
    vex_mem_t    mm;
    logic [31:0] imm;
    logic [31:0] stride;
    ar     = instr.arith;
    mm     = instr.mem;
    e      = '0;
    e.hops = 2'd1;
    imm    = {{27{ar.imm[4]}}, ar.imm};
    stride = mm.stride_type ? {{16{mm.stride[15]}}, mm.stride} : 32'd4;
    case (ar.iclass)
      LOAD, STORE: begin
        e.load  = (ar.iclass == LOAD);
        e.store = (ar.iclass == STORE);
        e.vd    = mm.vd;
        for (int i = 0; i < NUM_LANES; i++) begin
          e.wen[i]  = mask[i];
          e.data[i] = scalar.xs1 + 32'(i) * stride;
        end
      end
      CONFIG: begin
        e.cfg     = 1'b1;
        e.vd      = ar.vd;
        e.wb_data = (scalar.xs1 < NUM_LANES) ? scalar.xs1 : 32'(NUM_LANES);
      end
      default: begin
        e.vd = ar.vd;
        for (int i = 0; i < NUM_LANES; i++) begin
          e.wen[i]  = ar.mask_ena ? mask[i] : 1'b1;
          e.data[i] = alu_model(ar.aluop, source(ar.rs1_type, vs1[i], imm, scalar.xs1),
                                source(ar.rs2_type, vs2[i], imm, scalar.xs2));
        end
      end
    endcase
    return e;
  endfunction

  // kind 0 arith, 1 load or store, 2 config, 3 any of them
  task automatic randomize_instr(input int kind);
    vex_arith_t ar;
    vex_mem_t   mm;
    int         k;
    k          = (kind == 3) ? $urandom_range(0, 2) : kind;
    scalar.xs1 = $urandom();
    scalar.xs2 = $urandom();
    mask       = NUM_LANES'($urandom_range(0, (1 << NUM_LANES) - 1));
    for (int i = 0; i < NUM_LANES; i++) begin
      vs1[i] = $urandom();
      vs2[i] = $urandom();
    end
    if (k == 1) begin
      mm        = vex_mem_t'($urandom());
      mm.iclass = ($urandom_range(0, 1) != 0) ? STORE : LOAD;
      instr.mem = mm;
    end else begin
      ar       = vex_arith_t'($urandom());
      ar.aluop = vex_aluop_e'($urandom_range(0, 12));
      ar.iclass = (k == 2) ? CONFIG : ARITH;
      if (k == 2) begin
        // small lengths so both sides of the clamp show up
        scalar.xs1 = $urandom_range(0, 2 * NUM_LANES);
      end
      instr.arith = ar;
    end
  endtask

  task automatic check_outputs();
    expect_t e;
    logic    due;
    logic    in_dec;
    e      = '0;
    due    = (model.size() > 0) && (model[0].hops == 2'd2);
    in_dec = (model.size() > 0) && (model[model.size()-1].hops == 2'd1);
    if (due) begin
      e = model[0];
    end
    check_eq(res_valid, due, "res_valid");
    check_eq(busy, in_dec, "busy");
    check_eq(res_load, e.load, "res_load");
    check_eq(res_store, e.store, "res_store");
    check_eq(wb.wen, e.cfg, "wb.wen");
    for (int i = 0; i < NUM_LANES; i++) begin
      check_eq(lanes[i].wen, e.wen[i], $sformatf("lane %0d wen", i));
    end
    if (due) begin
      check_eq(res_vd, e.vd, "res_vd");
      if (e.cfg) begin
        check_eq(wb.rd, e.vd, "wb.rd");
        check_eq(wb.data, e.wb_data, "wb.data");
      end else begin
        for (int i = 0; i < NUM_LANES; i++) begin
          check_eq(lanes[i].data, e.data[i], $sformatf("lane %0d data", i));
        end
      end
    end
  endtask

  // mirrors the two registers for the coming edge
  task automatic advance_model();
    if (flush) begin
      model.delete();
    end else if (!stall) begin
      if (model.size() > 0 && model[0].hops == 2'd2) begin
        void'(model.pop_front());
      end
      foreach (model[j]) begin
        model[j].hops = model[j].hops + 2'd1;
      end
      if (issue) begin
        model.push_back(expected_result());
      end
    end
  endtask

  task automatic step(input int kind, input int stall_pct, input int flush_pct,
                      input int issue_pct);
    logic held;
    @(posedge CLK);
    #2;
    check_outputs();
    // a stalled issue stays on the inputs until taken
    held  = issue && stall && !flush;
    stall = ($urandom_range(1, 100) <= stall_pct);
    flush = ($urandom_range(1, 100) <= flush_pct);
    if (!held) begin
      issue = ($urandom_range(1, 100) <= issue_pct);
      if (issue) begin
        randomize_instr(kind);
      end
    end
    advance_model();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (model.size() > 0 && waited < MAX_WAIT) begin
      step(0, 0, 0, 0);
      waited++;
    end
    if (model.size() > 0) begin
      $display("timeout: a result never arrived within %0d cycles", MAX_WAIT);
      abort_run();
    end
  endtask

  initial begin
    void'($urandom(32'hf541_3ff5));
    nRST   = 1'b0;
    issue  = 1'b0;
    stall  = 1'b0;
    flush  = 1'b0;
    instr  = '0;
    scalar = '0;
    vs1    = '0;
    vs2    = '0;
    mask   = '0;
    repeat (8) @(posedge CLK);
    #2;
    check_outputs();
    nRST = 1'b1;
    // back to back arith, then memory and config, then everything under stall and flush
    repeat (400) step(0, 0, 0, 100);
    repeat (150) step(1, 0, 0, 80);
    repeat (40) step(2, 0, 0, 80);
    repeat (400) step(3, 20, 5, 70);
    drain();
    step(0, 0, 0, 0);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: hdl/vector_lane.sv
// one 32-bit lane; shifts use the low 5 bits of b and MUL keeps the low word
`timescale 1ns/1ps

module vector_lane
  import vex_pkg::*;
(
  input  vex_aluop_e   op,
  input  vex_lane_in_t lane_in,
  input  logic [31:0]  prev_addr,
  input  logic [31:0]  stride,
  output logic [31:0]  alu_data,
  output logic [31:0]  addr
);

  logic [31:0] a;
  logic [31:0] b;
  logic [4:0]  shamt;
  logic        lt_s;
  logic        lt_u;

  assign a     = lane_in.a;
  assign b     = lane_in.b;
  assign shamt = b[4:0];

  // shared compares for min and max
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (op)
      ADD: begin
        alu_data = a + b;
      end
      SUB: begin
        alu_data = a - b;
      end
      AND: begin
        alu_data = a & b;
      end
      OR: begin
        alu_data = a | b;
      end
      XOR: begin
        alu_data = a ^ b;
      end
      SLL: begin
        alu_data = a << shamt;
      end
      SRL: begin
        alu_data = a >> shamt;
      end
      SRA: begin
        alu_data = $signed(a) >>> shamt;
      end
      MIN: begin
        alu_data = lt_s ? a : b;
      end
      MAX: begin
        alu_data = lt_s ? b : a;
      end
      MINU: begin
        alu_data = lt_u ? a : b;
      end
      MAXU: begin
        alu_data = lt_u ? b : a;
      end
      MUL: begin
        // low 32 bits of the product
        alu_data = a * b;
      end
      default: begin
        alu_data = '0;
      end
    endcase
  end

  // link in the strided address chain
  assign addr = prev_addr + stride;

endmodule

// File: hdl/vex_decode.sv
// load/store lanes carry xs1 as operand a, which execute uses as the address base
`timescale 1ns/1ps

module vex_decode
  import vex_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         issue,
  input  vex_instr_u                   instr,
  input  vex_scalar_t                  scalar,
  input  logic [NUM_LANES-1:0][31:0]   vs1,
  input  logic [NUM_LANES-1:0][31:0]   vs2,
  input  logic [NUM_LANES-1:0]         mask,
  input  logic                         stall,
  input  logic                         flush,
  output logic                         dec_valid,
  output vex_ctrl_t                    dec_ctrl,
  output vex_lane_in_t [NUM_LANES-1:0] dec_lanes,
  output logic                         busy
);

  vex_arith_t                   ar;
  vex_mem_t                     mm;
  logic                         is_mem;
  logic [31:0]                  imm_ext;
  vex_ctrl_t                    ctrl_next;
  vex_lane_in_t [NUM_LANES-1:0] lanes_next;

  function automatic logic [31:0] pick(vex_src_e src, logic [31:0] vec, logic [31:0] imm,
                                       logic [31:0] xs);
    case (src)
      V:       return vec;
      I:       return imm;
      X:       return xs;
      default: return '0;
    endcase
  endfunction

  assign ar      = instr.arith;
  assign mm      = instr.mem;
  assign is_mem  = (ar.iclass == LOAD) || (ar.iclass == STORE);
  assign imm_ext = {{27{ar.imm[4]}}, ar.imm};

  always_comb begin
    ctrl_next.iclass = ar.iclass;
    ctrl_next.aluop  = ar.aluop;
    ctrl_next.vd     = is_mem ? mm.vd : ar.vd;
    // one word apart unless the instruction gives a stride
    ctrl_next.stride = mm.stride_type ? {{16{mm.stride[15]}}, mm.stride} : 32'd4;
    // granted length, clamped to the lane count
    ctrl_next.vl     = (scalar.xs1 < 32'(NUM_LANES)) ? scalar.xs1[5:0] : 6'(NUM_LANES);
  end

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (is_mem) begin
        // base in a, store data in b
        lanes_next[i].a    = scalar.xs1;
        lanes_next[i].b    = vs2[i];
        lanes_next[i].mask = mask[i];
      end else begin
        lanes_next[i].a    = pick(ar.rs1_type, vs1[i], imm_ext, scalar.xs1);
        lanes_next[i].b    = pick(ar.rs2_type, vs2[i], imm_ext, scalar.xs2);
        lanes_next[i].mask = ar.mask_ena ? mask[i] : 1'b1;
      end
    end
  end

  // flush beats stall
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      dec_valid <= 1'b0;
    end else if (flush) begin
      dec_valid <= 1'b0;
    end else if (!stall) begin
      dec_valid <= issue;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall && issue) begin
      dec_ctrl  <= ctrl_next;
      dec_lanes <= lanes_next;
    end
  end

  assign busy = dec_valid;

endmodule

// File: hdl/vex_execute.sv
// purely combinational; lane wen is already gated by dec_valid and the class
`timescale 1ns/1ps

module vex_execute
  import vex_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                          dec_valid,
  input  vex_ctrl_t                     dec_ctrl,
  input  vex_lane_in_t [NUM_LANES-1:0]  dec_lanes,
  input  logic [31:0]                   scalar_base,
  output logic                          ex_valid,
  output vex_ctrl_t                     ex_ctrl,
  output vex_lane_out_t [NUM_LANES-1:0] ex_lanes
);

  logic [NUM_LANES:0][31:0]   chain;
  logic [NUM_LANES-1:0][31:0] alu_data;
  logic                       is_mem;
  logic                       lane_write;

  // back off by one stride so lane 0 lands on the base
  assign chain[0] = scalar_base - dec_ctrl.stride;

  assign is_mem     = (dec_ctrl.iclass == LOAD) || (dec_ctrl.iclass == STORE);
  // config writes only the scalar side
  assign lane_write = dec_valid && (dec_ctrl.iclass != CONFIG);

  generate
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      vector_lane u_lane (
        .op        (dec_ctrl.aluop),
        .lane_in   (dec_lanes[i]),
        .prev_addr (chain[i]),
        .stride    (dec_ctrl.stride),
        .alu_data  (alu_data[i]),
        .addr      (chain[i+1])
      );

      // address for memory ops, ALU result otherwise
      assign ex_lanes[i].data = is_mem ? chain[i+1] : alu_data[i];
      assign ex_lanes[i].wen  = lane_write && dec_lanes[i].mask;
    end
  endgenerate

  assign ex_valid = dec_valid;
  assign ex_ctrl  = dec_ctrl;

endmodule

// File: hdl/vex_pkg.sv
// 32-bit elements only; vd sits at different bits in the arith and memory views of the word
package vex_pkg;

  // instruction class, bits 31:30 of every instruction word
  typedef enum logic [1:0] {
    ARITH,
    LOAD,
    STORE,
    CONFIG
  } vex_class_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    MIN,
    MAX,
    MINU,
    MAXU,
    MUL
  } vex_aluop_e;

  // operand source; NONE reads as zero
  typedef enum logic [1:0] {
    V,
    I,
    X,
    NONE
  } vex_src_e;

  // arith view, also used for config
  typedef struct packed {
    vex_class_e  iclass;
    vex_aluop_e  aluop;
    vex_src_e    rs1_type;
    vex_src_e    rs2_type;
    logic        mask_ena;
    logic [4:0]  vd;
    logic [4:0]  imm;
    logic [10:0] reserved;
  } vex_arith_t;

  // memory view, for load and store
  typedef struct packed {
    vex_class_e  iclass;
    logic        stride_type;
    logic [4:0]  vd;
    logic [15:0] stride;
    logic [7:0]  reserved;
  } vex_mem_t;

  typedef union packed {
    vex_arith_t arith;
    vex_mem_t   mem;
  } vex_instr_u;

  typedef struct packed {
    logic [31:0] xs1;
    logic [31:0] xs2;
  } vex_scalar_t;

  // decoded fields that follow the instruction down the pipe
  typedef struct packed {
    vex_class_e  iclass;
    vex_aluop_e  aluop;
    logic [4:0]  vd;
    logic [31:0] stride;
    logic [5:0]  vl;
  } vex_ctrl_t;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        mask;
  } vex_lane_in_t;

  typedef struct packed {
    logic        wen;
    logic [31:0] data;
  } vex_lane_out_t;

  typedef struct packed {
    logic        wen;
    logic [4:0]  rd;
    logic [31:0] data;
  } vex_wb_t;

endpackage

// File: hdl/vex_result.sv
// execute-to-memory latch; flush clears the control bits even while stalled
`timescale 1ns/1ps

module vex_result
  import vex_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          ex_valid,
  input  vex_ctrl_t                     ex_ctrl,
  input  vex_lane_out_t [NUM_LANES-1:0] ex_lanes,
  input  logic                          stall,
  input  logic                          flush,
  output logic                          res_valid,
  output logic                          res_load,
  output logic                          res_store,
  output logic [4:0]                    res_vd,
  output vex_lane_out_t [NUM_LANES-1:0] lanes,
  output vex_wb_t                       wb
);

  logic [NUM_LANES-1:0]       wen_q;
  logic [NUM_LANES-1:0][31:0] data_q;
  logic                       wb_wen_q;
  logic [5:0]                 vl_q;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      res_valid <= 1'b0;
      res_load  <= 1'b0;
      res_store <= 1'b0;
      wen_q     <= '0;
      wb_wen_q  <= 1'b0;
    end else if (flush) begin
      res_valid <= 1'b0;
      res_load  <= 1'b0;
      res_store <= 1'b0;
      wen_q     <= '0;
      wb_wen_q  <= 1'b0;
    end else if (!stall) begin
      res_valid <= ex_valid;
      res_load  <= ex_valid && (ex_ctrl.iclass == LOAD);
      res_store <= ex_valid && (ex_ctrl.iclass == STORE);
      for (int i = 0; i < NUM_LANES; i++) begin
        wen_q[i] <= ex_lanes[i].wen;
      end
      // granted vl goes back to the scalar file
      wb_wen_q  <= ex_valid && (ex_ctrl.iclass == CONFIG);
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      res_vd <= ex_ctrl.vd;
      vl_q   <= ex_ctrl.vl;
      for (int i = 0; i < NUM_LANES; i++) begin
        data_q[i] <= ex_lanes[i].data;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lanes[i].wen  = wen_q[i];
      lanes[i].data = data_q[i];
    end
  end

  assign wb.wen  = wb_wen_q;
  assign wb.rd   = res_vd;
  assign wb.data = {26'b0, vl_q};

endmodule

// File: hdl/vex_top.sv
// issue must stay high until taken; stall and flush come from an external hazard unit
`timescale 1ns/1ps

module vex_top
  import vex_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          issue,
  input  vex_instr_u                    instr,
  input  vex_scalar_t                   scalar,
  input  logic [NUM_LANES-1:0][31:0]    vs1,
  input  logic [NUM_LANES-1:0][31:0]    vs2,
  input  logic [NUM_LANES-1:0]          mask,
  input  logic                          stall,
  input  logic                          flush,
  output logic                          res_valid,
  output logic                          res_load,
  output logic                          res_store,
  output logic [4:0]                    res_vd,
  output vex_lane_out_t [NUM_LANES-1:0] lanes,
  output vex_wb_t                       wb,
  output logic                          busy
);

  logic                          dec_valid;
  vex_ctrl_t                     dec_ctrl;
  vex_lane_in_t [NUM_LANES-1:0]  dec_lanes;
  logic                          ex_valid;
  vex_ctrl_t                     ex_ctrl;
  vex_lane_out_t [NUM_LANES-1:0] ex_lanes;

  vex_decode #(.NUM_LANES(NUM_LANES)) u_decode (
    .CLK, .nRST, .issue, .instr, .scalar, .vs1, .vs2, .mask, .stall, .flush,
    .dec_valid, .dec_ctrl, .dec_lanes, .busy
  );

  // registered xs1 rides in lane 0 operand a for memory ops
  vex_execute #(.NUM_LANES(NUM_LANES)) u_execute (
    .dec_valid, .dec_ctrl, .dec_lanes,
    .scalar_base (dec_lanes[0].a),
    .ex_valid, .ex_ctrl, .ex_lanes
  );

  vex_result #(.NUM_LANES(NUM_LANES)) u_result (
    .CLK, .nRST, .ex_valid, .ex_ctrl, .ex_lanes, .stall, .flush,
    .res_valid, .res_load, .res_store, .res_vd, .lanes, .wb
  );

endmodule

// File: vex_top.f
hdl/vex_pkg.sv
hdl/vector_lane.sv
hdl/vex_decode.sv
hdl/vex_execute.sv
hdl/vex_result.sv
hdl/vex_top.sv
bench/vex_tb.sv
